/* bench/fetch_front_tb.sv */
// Fetch front end testbench
`timescale 1ns/1ps

module fetch_front_tb;

	import fetch_pkg::*;

	// queue depth handed to the DUT.
	localparam int QUEUE_DEPTH = 4;
	// patterns in the data file.
	localparam int pat_count = 40;
	// the run is cut off past this many clock cycles.
	localparam int timeout_cycles = 20 * pat_count + 200;

	logic CLK;
	logic rst_n;
	logic [31:0] readout_word;
	logic [pc_width-1:0] readout_pc;
	logic readout_valid;
	logic readout_ready;
	logic decode_ready;
	queue_entry_s decode_entry;
	logic decode_valid;
	logic flush;

	// four slots per pattern: word, pc, is_rvc, class.
	logic [63:0] pat_mem [4*pat_count];
	// pattern numbers in the order decode has to see them.
	int exp_q [$];
	// patterns taken by the DUT so far, wraps over the file.
	int next_pat;
	// words taken in the current phase.
	int accepted;
	int cycle_count;
	int seed;
	// falling edges from accept until decode_valid shows.
	int waited;

	fetch_front #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) fetch_front_inst (
		.readout_word  (readout_word),
		.readout_pc    (readout_pc),
		.readout_valid (readout_valid),
		.readout_ready (readout_ready),
		.decode_ready  (decode_ready),
		.decode_entry  (decode_entry),
		.decode_valid  (decode_valid),
		.flush         (flush),
		.CLK           (CLK),
		.rst_n         (rst_n)
	);

	// 20 ns clock.
	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	// print why the run stops, then end it.
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1);
	endtask

	// compare one observed value with its expected value.
	task automatic expect_equal(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	// the entry decode takes must be the oldest accepted pattern.
	task automatic compare_head();
		int idx;
		if (exp_q.size() == 0) begin
			abort_run("decode_valid is high while no word is expected");
		end else begin
			idx = exp_q.pop_front();
			expect_equal("decode_entry.word", decode_entry.word, pat_mem[4*idx]);
			expect_equal("decode_entry.pc", decode_entry.pc, pat_mem[4*idx+1]);
			expect_equal("decode_entry.is_rvc", decode_entry.is_rvc, pat_mem[4*idx+2]);
			expect_equal("decode_entry.iclass", decode_entry.iclass, pat_mem[4*idx+3]);
		end
	endtask

	// one clock of stimulus on the falling edge.
	// the model follows what the next rising edge will do.
	task automatic run_cycle(input bit offer, input bit take, input bit kill);
		int idx;
		@(negedge CLK);
		idx = next_pat % pat_count;
		readout_word = pat_mem[4*idx][31:0];
		readout_pc = pat_mem[4*idx+1];
		readout_valid = offer;
		decode_ready = take;
		flush = kill;
		if (kill) begin
			// stage word, queue and the word on offer are all dropped.
			exp_q.delete();
		end else begin
			// these outputs moved on the last rising edge and hold until the next.
			if (decode_valid && decode_ready) begin
				compare_head();
			end
			if (readout_valid && readout_ready) begin
				exp_q.push_back(idx);
				next_pat++;
				accepted++;
			end
		end
	endtask

	// let decode take everything, then make sure nothing more shows up.
	task automatic drain();
		while (exp_q.size() != 0) begin
			run_cycle(1'b0, 1'b1, 1'b0);
		end
		repeat (3) begin
			run_cycle(1'b0, 1'b1, 1'b0);
		end
	endtask

	// watchdog.
	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			abort_run($sformatf("run did not finish within %0d clock cycles",
				timeout_cycles));
		end
	end

	initial begin
		seed = 32'h4843;
		cycle_count = 0;
		next_pat = 0;
		accepted = 0;
		waited = 0;
		rst_n = 1'b0;
		readout_word = '0;
		readout_pc = '0;
		readout_valid = 1'b0;
		decode_ready = 1'b0;
		flush = 1'b0;
		$readmemh("bench/fetch_patterns.mem", pat_mem);
		if ((^pat_mem[4*pat_count-1]) === 1'bx) begin
			abort_run("pattern file bench/fetch_patterns.mem is missing or short");
		end

		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
		// idle state straight out of reset.
		expect_equal("decode_valid", decode_valid, 1'b0);
		expect_equal("readout_ready", readout_ready, 1'b1);

		// one word into an empty queue, decode always ready.
		run_cycle(1'b1, 1'b1, 1'b0);
		do begin
			run_cycle(1'b0, 1'b1, 1'b0);
			waited++;
		end while (!decode_valid && waited < 8);
		expect_equal("decode_valid latency", waited, 2);
		drain();

		// random gaps from memory and random decode stalls over the whole file.
		while (next_pat < pat_count) begin
			run_cycle(($random(seed) & 3) != 0, ($random(seed) & 3) != 0, 1'b0);
		end
		drain();

		// decode stalled while memory keeps offering.
		accepted = 0;
		repeat (10) begin
			run_cycle(1'b1, 1'b0, 1'b0);
		end
		if (accepted > QUEUE_DEPTH) begin
			abort_run($sformatf("%0d words were taken while decode stalled, room for %0d",
				accepted, QUEUE_DEPTH));
		end
		expect_equal("readout_ready", readout_ready, 1'b0);
		expect_equal("decode_valid", decode_valid, 1'b1);
		// decode comes back, the waiting word goes in after the queue.
		repeat (6) begin
			run_cycle(1'b1, 1'b1, 1'b0);
		end
		drain();

		// words in stage and queue, then a flush with one more on offer.
		repeat (3) begin
			run_cycle(1'b1, 1'b0, 1'b0);
		end
		run_cycle(1'b1, 1'b1, 1'b1);
		run_cycle(1'b0, 1'b1, 1'b0);
		expect_equal("decode_valid", decode_valid, 1'b0);
		run_cycle(1'b0, 1'b1, 1'b0);
		expect_equal("decode_valid", decode_valid, 1'b0);
		// traffic after the flush.
		repeat (8) begin
			run_cycle(1'b1, 1'b1, 1'b0);
		end
		drain();

		$display("All checks passed");
		$finish;
	end

endmodule

/* bench/fetch_patterns.mem */
// word pc is_rvc class, one pattern per line
// class codes: load 0, store 1, branch 2, jal 3, jalr 4, alu 5, system 6, other 7
00813283 0000004a80000000 0 0
00513823 0000004a80000004 0 1
00208463 0000004a80000008 0 2
010000ef 0000004a8000000c 0 3
00008067 0000004a80000010 0 4
00100093 0000004a80000014 0 5
002081b3 0000004a80000018 0 5
002081bb 0000004a8000001c 0 5
0010809b 0000004a80000020 0 5
123452b7 0000004a80000024 0 5
00000297 0000004a80000028 0 5
00000073 0000004a8000002c 0 6
30029073 0000004a80000030 0 6
0ff0000f 0000004a80000034 0 7
00012007 0000004a80000038 0 7
00000040 0000004a8000003c 1 7
a5a54108 0000004a80000040 1 0
00006108 0000004a80000044 1 0
ffffc108 0000004a80000048 1 1
1234e108 0000004a8000004c 1 1
00002108 0000004a80000050 1 7
00008000 0000004a80000054 1 7
00000085 0000004a80000058 1 5
beef4085 0000004a8000005c 1 5
00006085 0000004a80000060 1 5
00008c05 0000004a80000064 1 5
0000a001 0000004a80000068 1 3
7777c001 0000004a8000006c 1 2
0000e001 0000004a80000070 1 2
00000086 0000004a80000074 1 5
00004082 0000004a80000078 1 0
c0de6082 0000004a8000007c 1 0
0000c006 0000004a80000080 1 1
0000e006 0000004a80000084 1 1
00008082 0000004a80000088 1 4
ffff9082 0000004a8000008c 1 4
0000808a 0000004a80000090 1 5
00009002 0000004a80000094 1 5
00009086 0000004a80000098 1 5
55552082 0000004a8000009c 1 7

/* filelist.f */
source/fetch_pkg.sv
source/fetch_stage.sv
source/rvc_predecode.sv
source/instr_queue.sv
source/fetch_front.sv
bench/fetch_front_tb.sv

/* source/fetch_front.sv */
// Instruction fetch front end
`timescale 1ns/1ps

module fetch_front #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic [31:0]                    readout_word,
	input  logic [fetch_pkg::pc_width-1:0] readout_pc,
	input  logic                           readout_valid,
	output logic                           readout_ready,
	input  logic                           decode_ready,
	output fetch_pkg::queue_entry_s        decode_entry,
	output logic                           decode_valid,
	input  logic                           flush,
	input  logic                           CLK,
	input  logic                           rst_n
);

	import fetch_pkg::*;

	// stage contents toward the queue.
	stage_out_s stage_out;
	// predecode of the same word.
	predecode_s pre_out;
	logic almost_full;
	// word taken from memory on this edge.
	logic accept;

	// memory is held off once the queue nears full.
	assign readout_ready = ~almost_full;
	assign accept = readout_valid & ~almost_full;

	fetch_stage fetch_stage_inst (
		.readout_word (readout_word),
		.readout_pc   (readout_pc),
		.accept       (accept),
		.flush        (flush),
		.CLK          (CLK),
		.rst_n        (rst_n),
		.stage_out    (stage_out)
	);

	// runs beside the stage on the same accept.
	rvc_predecode rvc_predecode_inst (
		.readout_word (readout_word),
		.accept       (accept),
		.flush        (flush),
		.CLK          (CLK),
		.rst_n        (rst_n),
		.pre_out      (pre_out)
	);

	instr_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) instr_queue_inst (
		.stage_out    (stage_out),
		.pre_out      (pre_out),
		.decode_ready (decode_ready),
		.flush        (flush),
		.CLK          (CLK),
		.rst_n        (rst_n),
		.decode_entry (decode_entry),
		.decode_valid (decode_valid),
		.almost_full  (almost_full)
	);

endmodule

/* source/fetch_pkg.sv */
// Fetch front end shared types
package fetch_pkg;

	// width of the program counter on this core.
	parameter int pc_width = 64;

	// coarse instruction class handed on to decode.
	typedef enum logic [2:0] {
		class_load,
		class_store,
		class_branch,
		class_jal,
		class_jalr,
		class_alu,
		class_system,
		class_other
	} instr_class_e;

	// base 32-bit encoding split into its standard fields.
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} full_view_s;

	// compressed encoding lives in the low half only.
	// body covers bits 12 to 2 of the halfword.
	typedef struct packed {
		logic [15:0] upper;
		logic [2:0]  funct3_c;
		logic [10:0] body;
		logic [1:0]  quadrant;
	} comp_view_s;

	// one fetched word seen either as base or as compressed code.
	typedef union packed {
		full_view_s full;
		comp_view_s comp;
	} fetch_word_u;

	// contents of the fetch register stage.
	typedef struct packed {
		fetch_word_u         word;
		logic [pc_width-1:0] pc;
		logic                valid;
	} stage_out_s;

	// registered predecode result for the same word.
	typedef struct packed {
		logic         is_rvc;
		instr_class_e iclass;
	} predecode_s;

	// one queue slot as presented to decode.
	typedef struct packed {
		logic [31:0]         word;
		logic [pc_width-1:0] pc;
		logic                is_rvc;
		instr_class_e        iclass;
	} queue_entry_s;

endpackage

/* source/fetch_stage.sv */
// Fetch register stage
`timescale 1ns/1ps

module fetch_stage (
	input  fetch_pkg::fetch_word_u         readout_word,
	input  logic [fetch_pkg::pc_width-1:0] readout_pc,
	input  logic                           accept,
	input  logic                           flush,
	input  logic                           CLK,
	input  logic                           rst_n,
	output fetch_pkg::stage_out_s          stage_out
);

	import fetch_pkg::*;

	// held instruction word.
	fetch_word_u word_q;
	// pc that came with the word.
	logic [pc_width-1:0] pc_q;
	// a word was taken on the last edge.
	logic valid_q;

	// valid lasts one cycle per accepted word.
	// the queue pushes on it, so it must never repeat.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			// a word offered with the flush is dropped here.
			valid_q <= 1'b0;
		end else begin
			valid_q <= accept;
		end
	end

	// payload keeps its value while memory is held off.
	always_ff @(posedge CLK) begin
		if (flush) begin
			word_q <= '0;
			pc_q <= '0;
		end else if (accept) begin
			word_q <= readout_word;
			pc_q <= readout_pc;
		end
	end

	// pack the stage result for the queue.
	assign stage_out.word = word_q;
	assign stage_out.pc = pc_q;
	assign stage_out.valid = valid_q;

	// memory must present a defined word and pc when one is taken.
	// an unknown word would reach the queue with a garbage class.
	assert property (@(posedge CLK) disable iff (!rst_n)
		accept |-> !$isunknown({readout_word, readout_pc}))
		else $error("fetch stage took an undefined word or pc");

endmodule

/* source/instr_queue.sv */
// Instruction queue
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  fetch_pkg::stage_out_s   stage_out,
	input  fetch_pkg::predecode_s   pre_out,
	input  logic                    decode_ready,
	input  logic                    flush,
	input  logic                    CLK,
	input  logic                    rst_n,
	output fetch_pkg::queue_entry_s decode_entry,
	output logic                    decode_valid,
	output logic                    almost_full
);

	import fetch_pkg::*;

	// pointer and count widths.
	localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

	// entry storage.
	queue_entry_s entry_mem [QUEUE_DEPTH];
	// stage word joined with its predecode.
	queue_entry_s push_entry;
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;
	logic pop;

	// step a pointer and wrap at the last slot.
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// stage and predecode describe the same word in this cycle.
	assign push_entry.word = stage_out.word;
	assign push_entry.pc = stage_out.pc;
	assign push_entry.is_rvc = pre_out.is_rvc;
	assign push_entry.iclass = pre_out.iclass;

	// every valid stage word goes in.
	assign push = stage_out.valid;
	assign pop = decode_valid & decode_ready;

	// first word falls through to decode.
	assign decode_valid = (count != '0);
	assign decode_entry = entry_mem[rd_ptr];

	// one slot stays free for the word already in the stage.
	assign almost_full = (count >= cnt_w'(QUEUE_DEPTH - 1));

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			// drop everything, including a push in this cycle.
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// slot write.
	always_ff @(posedge CLK) begin
		if (push) begin
			entry_mem[wr_ptr] <= push_entry;
		end
	end

	// readout_ready upstream must have held the stage back in time.
	assert property (@(posedge CLK) disable iff (!rst_n)
		push |-> (count != cnt_w'(QUEUE_DEPTH)))
		else $error("push into a full instruction queue");

endmodule

/* source/rvc_predecode.sv */
// RVC predecode
`timescale 1ns/1ps

module rvc_predecode (
	input  fetch_pkg::fetch_word_u readout_word,
	input  logic                   accept,
	input  logic                   flush,
	input  logic                   CLK,
	input  logic                   rst_n,
	output fetch_pkg::predecode_s  pre_out
);

	import fetch_pkg::*;

	// compressed flag of the incoming word.
	logic rvc_d;
	// class of the incoming word.
	instr_class_e class_d;
	// result register, aligned with the fetch stage.
	predecode_s pre_q;

	// a word is compressed unless both low bits are set.
	assign rvc_d = (readout_word.comp.quadrant != 2'b11);

	always_comb begin
		class_d = class_other;
		if (!rvc_d) begin
			// full width word, the major opcode decides.
			case (readout_word.full.opcode)
				7'b0000011: class_d = class_load;
				7'b0100011: class_d = class_store;
				7'b1100011: class_d = class_branch;
				7'b1101111: class_d = class_jal;
				7'b1100111: class_d = class_jalr;
				7'b1110011: class_d = class_system;
				// op, op-imm, op-32, op-imm-32, lui and auipc.
				7'b0110011, 7'b0010011, 7'b0111011,
				7'b0011011, 7'b0110111, 7'b0010111: class_d = class_alu;
				default: class_d = class_other;
			endcase
		end else begin
			// only the low half counts here.
			case (readout_word.comp.quadrant)
				2'b00: begin
					// c.lw and c.ld, c.sw and c.sd.
					case (readout_word.comp.funct3_c)
						3'b010, 3'b011: class_d = class_load;
						3'b110, 3'b111: class_d = class_store;
						default: class_d = class_other;
					endcase
				end
				2'b01: begin
					// immediates and arithmetic, then c.j and the branches.
					case (readout_word.comp.funct3_c)
						3'b101: class_d = class_jal;
						3'b110, 3'b111: class_d = class_branch;
						default: class_d = class_alu;
					endcase
				end
				2'b10: begin
					case (readout_word.comp.funct3_c)
						3'b000: class_d = class_alu;
						3'b010, 3'b011: class_d = class_load;
						3'b110, 3'b111: class_d = class_store;
						3'b100: begin
							// c.jr and c.jalr have rs2 zero and rs1 set.
							if (readout_word.comp.body[4:0] == 5'd0
								&& readout_word.comp.body[9:5] != 5'd0) begin
								class_d = class_jalr;
							end else begin
								class_d = class_alu;
							end
						end
						default: class_d = class_other;
					endcase
				end
				default: class_d = class_other;
			endcase
		end
	end

	// loads on the same edge as the fetch stage.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pre_q <= '0;
		end else if (flush) begin
			pre_q <= '0;
		end else if (accept) begin
			pre_q.is_rvc <= rvc_d;
			pre_q.iclass <= class_d;
		end
	end

	assign pre_out = pre_q;

endmodule
